//--- design/soc_bus_pkg.sv
package soc_bus_pkg;

  // one word access from a requester to memory or a device
  // addr is a byte address, word aligned
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        we;
  } mem_req_t;

  // response payload, zero for stores
  typedef struct packed {
    logic [31:0] rdata;
  } mem_rsp_t;

  // mtime low word, the high word follows at +4
  localparam logic [31:0] CLINT_MTIME_ADDR = 32'h0200_bff8;

  // uart data register, write only
  localparam logic [31:0] UART_TX_ADDR = 32'ha000_03f8;

  // where an lsu request ends up
  typedef enum logic [1:0] {
    TGT_SRAM  = 2'd0,
    TGT_CLINT = 2'd1,
    TGT_UART  = 2'd2
  } mem_target_e;

endpackage

//--- design/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter #(
  parameter int SRAM_LATENCY = 2
) (
  input  logic                  clk,
  input  logic                  rst,

  // instruction fetch port
  input  logic                  ifu_req_valid_i,
  input  soc_bus_pkg::mem_req_t ifu_req_i,
  output logic                  ifu_rsp_valid_o,
  output soc_bus_pkg::mem_rsp_t ifu_rsp_o,

  // load/store port
  input  logic                  lsu_req_valid_i,
  input  soc_bus_pkg::mem_req_t lsu_req_i,
  output logic                  lsu_rsp_valid_o,
  output soc_bus_pkg::mem_rsp_t lsu_rsp_o,

  // shared sram
  output logic                  sram_req_valid_o,
  output soc_bus_pkg::mem_req_t sram_req_o,
  input  logic                  sram_rsp_valid_i,
  input  soc_bus_pkg::mem_rsp_t sram_rsp_i,

  // device requests, straight from the lsu
  output logic                  clint_rd_valid_o,
  output soc_bus_pkg::mem_req_t clint_req_o,
  output logic                  uart_wr_valid_o,
  output soc_bus_pkg::mem_req_t uart_req_o,

  // device responses
  input  logic                  clint_rsp_valid_i,
  input  soc_bus_pkg::mem_rsp_t clint_rsp_i,
  input  logic                  uart_rsp_valid_i
);

  import soc_bus_pkg::*;

  localparam int CNT_W = $clog2(SRAM_LATENCY + 1);

  mem_target_e lsu_tgt;

  logic        ifu_pend_q;
  mem_req_t    ifu_req_q;
  logic        lsu_pend_q;
  mem_req_t    lsu_req_q;

  logic [CNT_W-1:0] inflight_q;
  logic             owner_lsu_q;
  logic             sram_busy;
  logic             grant_lsu;
  logic             grant_ifu;

  logic        dev_rsp_valid_q;
  mem_rsp_t    dev_rsp_q;

  // lsu address decode
  always_comb
  begin
    lsu_tgt = TGT_SRAM;
    if (!lsu_req_i.we &&
        (lsu_req_i.addr == CLINT_MTIME_ADDR || lsu_req_i.addr == CLINT_MTIME_ADDR + 32'd4))
    begin
      lsu_tgt = TGT_CLINT;
    end
    else if (lsu_req_i.we && lsu_req_i.addr == UART_TX_ADDR)
    begin
      lsu_tgt = TGT_UART;
    end
  end

  // device paths skip the pending registers
  assign clint_rd_valid_o = lsu_req_valid_i && (lsu_tgt == TGT_CLINT);
  assign uart_wr_valid_o  = lsu_req_valid_i && (lsu_tgt == TGT_UART);
  assign clint_req_o      = lsu_req_i;
  assign uart_req_o       = lsu_req_i;

  // one access in flight at a time, lsu first
  assign sram_busy = (inflight_q != '0);
  assign grant_lsu = lsu_pend_q && !sram_busy;
  assign grant_ifu = ifu_pend_q && !lsu_pend_q && !sram_busy;

  assign sram_req_valid_o = grant_lsu || grant_ifu;
  assign sram_req_o       = grant_lsu ? lsu_req_q : ifu_req_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ifu_pend_q <= 1'b0;
      lsu_pend_q <= 1'b0;
    end
    else
    begin
      if (ifu_req_valid_i)
        ifu_pend_q <= 1'b1;
      else if (grant_ifu)
        ifu_pend_q <= 1'b0;

      if (lsu_req_valid_i && lsu_tgt == TGT_SRAM)
        lsu_pend_q <= 1'b1;
      else if (grant_lsu)
        lsu_pend_q <= 1'b0;
    end
  end

  // request payloads
  always_ff @(posedge clk)
  begin
    if (ifu_req_valid_i)
      ifu_req_q <= ifu_req_i;
    if (lsu_req_valid_i)
      lsu_req_q <= lsu_req_i;
  end

  // counts down to the response cycle, so the owner is known without tags
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inflight_q  <= '0;
      owner_lsu_q <= 1'b0;
    end
    else if (sram_req_valid_o)
    begin
      inflight_q  <= CNT_W'(SRAM_LATENCY);
      owner_lsu_q <= grant_lsu;
    end
    else if (sram_busy)
    begin
      inflight_q <= inflight_q - 1'b1;
    end
  end

  // device responses get one register stage here
  always_ff @(posedge clk)
  begin
    if (rst)
      dev_rsp_valid_q <= 1'b0;
    else
      dev_rsp_valid_q <= clint_rsp_valid_i || uart_rsp_valid_i;
  end

  always_ff @(posedge clk)
  begin
    // uart acks carry no data
    dev_rsp_q <= clint_rsp_valid_i ? clint_rsp_i : '0;
  end

  assign ifu_rsp_valid_o = sram_rsp_valid_i && !owner_lsu_q;
  assign ifu_rsp_o       = sram_rsp_i;

  // device and sram responses to the lsu never overlap
  assign lsu_rsp_valid_o = dev_rsp_valid_q || (sram_rsp_valid_i && owner_lsu_q);
  assign lsu_rsp_o       = dev_rsp_valid_q ? dev_rsp_q : sram_rsp_i;

  a_ifu_one_outstanding: assert property (@(posedge clk) disable iff (rst)
    ifu_req_valid_i |-> !ifu_pend_q);

  a_lsu_one_outstanding: assert property (@(posedge clk) disable iff (rst)
    (lsu_req_valid_i && lsu_tgt == TGT_SRAM) |-> !lsu_pend_q);

  a_ifu_no_store: assert property (@(posedge clk) disable iff (rst)
    ifu_req_valid_i |-> !ifu_req_i.we);

  // sram answer must line up with the last count of the in-flight access
  a_sram_rsp_in_flight: assert property (@(posedge clk) disable iff (rst)
    sram_rsp_valid_i |-> inflight_q == CNT_W'(1));

endmodule

//--- design/sram_memory.sv
`timescale 1ns/1ns

module sram_memory #(
  parameter int SRAM_LATENCY = 2,
  parameter int MEM_WORDS    = 256
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid_i,
  input  soc_bus_pkg::mem_req_t req_i,
  output logic                  rsp_valid_o,
  output soc_bus_pkg::mem_rsp_t rsp_o
);

  import soc_bus_pkg::*;

  // upper address bits wrap around the power-of-two depth
  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [31:0]             mem [MEM_WORDS];
  logic [IDX_W-1:0]        word_idx;
  logic [SRAM_LATENCY-1:0] vld_q;
  mem_rsp_t                data_q [SRAM_LATENCY];
  mem_rsp_t                rd_word;

  assign word_idx = req_i.addr[IDX_W+1:2];

  // stores answer with zero data
  assign rd_word.rdata = req_i.we ? 32'd0 : mem[word_idx];

  // byte-enable write
  always_ff @(posedge clk)
  begin
    if (req_valid_i && req_i.we)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (req_i.wstrb[b])
          mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
      end
    end
  end

  // stage 0 of the response pipeline loads on the request edge
  always_ff @(posedge clk)
  begin
    if (rst)
      vld_q <= '0;
    else
      vld_q <= SRAM_LATENCY'({vld_q, req_valid_i});
  end

  always_ff @(posedge clk)
  begin
    data_q[0] <= rd_word;
    for (int i = 1; i < SRAM_LATENCY; i++)
    begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign rsp_valid_o = vld_q[SRAM_LATENCY-1];
  assign rsp_o       = data_q[SRAM_LATENCY-1];

endmodule

//--- design/clint_timer.sv
`timescale 1ns/1ns

module clint_timer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rd_valid_i,
  input  soc_bus_pkg::mem_req_t req_i,
  output logic                  rsp_valid_o,
  output soc_bus_pkg::mem_rsp_t rsp_o
);

  import soc_bus_pkg::*;

  logic [63:0] mtime_q;
  logic        rsp_valid_q;
  mem_rsp_t    rsp_q;

  // free-running, 0 in the first cycle out of reset
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= 64'd0;
    else
      mtime_q <= mtime_q + 64'd1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rsp_valid_q <= 1'b0;
    else
      rsp_valid_q <= rd_valid_i;
  end

  // addr bit 2 picks the high word
  always_ff @(posedge clk)
  begin
    if (rd_valid_i)
    begin
      if (req_i.addr[2])
        rsp_q.rdata <= mtime_q[63:32];
      else
        rsp_q.rdata <= mtime_q[31:0];
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

//--- design/uart_tx_port.sv
`timescale 1ns/1ns

module uart_tx_port (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr_valid_i,
  input  soc_bus_pkg::mem_req_t req_i,
  output logic                  rsp_valid_o,
  output logic                  tx_valid_o,
  output logic [7:0]            tx_data_o
);

  logic [7:0] lane_byte;
  logic       lane_hit;
  logic       tx_valid_q;
  logic [7:0] tx_data_q;
  logic       rsp_valid_q;

  // lowest enabled lane wins, so scan from the top down
  always_comb
  begin
    lane_byte = 8'd0;
    lane_hit  = 1'b0;
    for (int b = 3; b >= 0; b--)
    begin
      if (req_i.wstrb[b])
      begin
        lane_byte = req_i.wdata[8*b +: 8];
        lane_hit  = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tx_valid_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end
    else
    begin
      // an empty strobe is only acknowledged
      tx_valid_q  <= wr_valid_i && lane_hit;
      rsp_valid_q <= wr_valid_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_valid_i)
      tx_data_q <= lane_byte;
  end

  assign tx_valid_o  = tx_valid_q;
  assign tx_data_o   = tx_data_q;
  assign rsp_valid_o = rsp_valid_q;

endmodule

//--- design/soc_bus_top.sv
`timescale 1ns/1ns

module soc_bus_top #(
  parameter int SRAM_LATENCY = 2,
  parameter int MEM_WORDS    = 256
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  ifu_req_valid_i,
  input  soc_bus_pkg::mem_req_t ifu_req_i,
  output logic                  ifu_rsp_valid_o,
  output soc_bus_pkg::mem_rsp_t ifu_rsp_o,

  input  logic                  lsu_req_valid_i,
  input  soc_bus_pkg::mem_req_t lsu_req_i,
  output logic                  lsu_rsp_valid_o,
  output soc_bus_pkg::mem_rsp_t lsu_rsp_o,

  output logic                  uart_tx_valid_o,
  output logic [7:0]            uart_tx_data_o
);

  import soc_bus_pkg::*;

  logic     sram_req_valid;
  mem_req_t sram_req;
  logic     sram_rsp_valid;
  mem_rsp_t sram_rsp;

  logic     clint_rd_valid;
  mem_req_t clint_req;
  logic     clint_rsp_valid;
  mem_rsp_t clint_rsp;

  logic     uart_wr_valid;
  mem_req_t uart_req;
  logic     uart_rsp_valid;

  bus_arbiter #(
    .SRAM_LATENCY (SRAM_LATENCY)
  ) u_arbiter (
    .clk               (clk),
    .rst               (rst),
    .ifu_req_valid_i   (ifu_req_valid_i),
    .ifu_req_i         (ifu_req_i),
    .ifu_rsp_valid_o   (ifu_rsp_valid_o),
    .ifu_rsp_o         (ifu_rsp_o),
    .lsu_req_valid_i   (lsu_req_valid_i),
    .lsu_req_i         (lsu_req_i),
    .lsu_rsp_valid_o   (lsu_rsp_valid_o),
    .lsu_rsp_o         (lsu_rsp_o),
    .sram_req_valid_o  (sram_req_valid),
    .sram_req_o        (sram_req),
    .sram_rsp_valid_i  (sram_rsp_valid),
    .sram_rsp_i        (sram_rsp),
    .clint_rd_valid_o  (clint_rd_valid),
    .clint_req_o       (clint_req),
    .uart_wr_valid_o   (uart_wr_valid),
    .uart_req_o        (uart_req),
    .clint_rsp_valid_i (clint_rsp_valid),
    .clint_rsp_i       (clint_rsp),
    .uart_rsp_valid_i  (uart_rsp_valid)
  );

  sram_memory #(
    .SRAM_LATENCY (SRAM_LATENCY),
    .MEM_WORDS    (MEM_WORDS)
  ) u_sram (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (sram_req_valid),
    .req_i       (sram_req),
    .rsp_valid_o (sram_rsp_valid),
    .rsp_o       (sram_rsp)
  );

  clint_timer u_clint (
    .clk         (clk),
    .rst         (rst),
    .rd_valid_i  (clint_rd_valid),
    .req_i       (clint_req),
    .rsp_valid_o (clint_rsp_valid),
    .rsp_o       (clint_rsp)
  );

  uart_tx_port u_uart (
    .clk         (clk),
    .rst         (rst),
    .wr_valid_i  (uart_wr_valid),
    .req_i       (uart_req),
    .rsp_valid_o (uart_rsp_valid),
    .tx_valid_o  (uart_tx_valid_o),
    .tx_data_o   (uart_tx_data_o)
  );

endmodule

//--- verification/soc_bus_tb.sv
`timescale 1ns/1ns

module soc_bus_tb;

  import soc_bus_pkg::*;

  localparam int SRAM_LATENCY = 2;
  localparam int MEM_WORDS    = 256;
  localparam int CLK_PERIOD   = 4;
  localparam int RSP_TIMEOUT  = 50;

  localparam int N_STORE_LOAD = 24;
  localparam int N_FETCH      = 16;
  localparam int N_CONTEND    = 12;
  localparam int N_CLINT      = 10;
  localparam int N_UART       = 8;
  // pairs count twice, uart phase adds one setup store and two loads
  localparam int TOTAL_OPS = 2 * N_STORE_LOAD + N_FETCH + 2 * N_CONTEND + N_CLINT + N_UART + 3;
  localparam int WATCHDOG_NS = (TOTAL_OPS * RSP_TIMEOUT + 20) * CLK_PERIOD;

  // one expected response and when its request was strobed
  typedef struct packed {
    mem_rsp_t    rsp;
    logic [63:0] strobe_cyc;
    logic [31:0] lat;
  } exp_t;

  logic       clk;
  logic       rst;
  logic       ifu_req_valid;
  mem_req_t   ifu_req;
  logic       ifu_rsp_valid;
  mem_rsp_t   ifu_rsp;
  logic       lsu_req_valid;
  mem_req_t   lsu_req;
  logic       lsu_rsp_valid;
  mem_rsp_t   lsu_rsp;
  logic       uart_tx_valid;
  logic [7:0] uart_tx_data;

  exp_t        exp_lsu_q[$];
  exp_t        exp_ifu_q[$];
  logic [7:0]  exp_tx_q[$];
  logic [31:0] written_q[$];

  logic [31:0] model_mem [MEM_WORDS];
  bit          model_init [MEM_WORDS];
  logic [31:0] lfsr_state = 32'he794eaab;

  logic [63:0] cyc;
  logic [63:0] lsu_last_cyc;
  logic [63:0] ifu_last_cyc;
  int          lsu_rsp_cnt = 0;
  int          ifu_rsp_cnt = 0;

  soc_bus_top #(
    .SRAM_LATENCY (SRAM_LATENCY),
    .MEM_WORDS    (MEM_WORDS)
  ) DUT (
    .clk             (clk),
    .rst             (rst),
    .ifu_req_valid_i (ifu_req_valid),
    .ifu_req_i       (ifu_req),
    .ifu_rsp_valid_o (ifu_rsp_valid),
    .ifu_rsp_o       (ifu_rsp),
    .lsu_req_valid_i (lsu_req_valid),
    .lsu_req_i       (lsu_req),
    .lsu_rsp_valid_o (lsu_rsp_valid),
    .lsu_rsp_o       (lsu_rsp),
    .uart_tx_valid_o (uart_tx_valid),
    .uart_tx_data_o  (uart_tx_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // cycles since reset release, mtime follows the same count
  always @(posedge clk)
  begin
    if (rst)
      cyc <= 64'd0;
    else
      cyc <= cyc + 64'd1;
  end

  // right-shifting Galois form, taps for x^32+x^31+x^29+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic int word_index(input logic [31:0] addr);
    return int'((addr >> 2) % MEM_WORDS);
  endfunction

  function automatic mem_req_t make_req(input logic [31:0] addr, input logic we,
                                        input logic [3:0] wstrb, input logic [31:0] wdata);
    mem_req_t r;
    r.addr  = addr;
    r.we    = we;
    r.wstrb = wstrb;
    r.wdata = wdata;
    return r;
  endfunction

  // expected response word for a request strobed when mtime was at mtime
  function automatic mem_rsp_t ref_rsp(input mem_req_t req, input logic [63:0] mtime);
    mem_rsp_t r;
    r.rdata = 32'd0;
    if (req.we)
      r.rdata = 32'd0;
    else if (req.addr == CLINT_MTIME_ADDR)
      r.rdata = mtime[31:0];
    else if (req.addr == CLINT_MTIME_ADDR + 32'd4)
      r.rdata = mtime[63:32];
    else
      r.rdata = model_mem[word_index(req.addr)];
    return r;
  endfunction

  // lowest enabled lane
  function automatic logic [7:0] ref_tx_byte(input mem_req_t req);
    casez (req.wstrb)
      4'b???1: return req.wdata[7:0];
      4'b??10: return req.wdata[15:8];
      4'b?100: return req.wdata[23:16];
      4'b1000: return req.wdata[31:24];
      default: return 8'd0;
    endcase
  endfunction

  task automatic model_write(input mem_req_t req);
    int idx;
    idx = word_index(req.addr);
    for (int b = 0; b < 4; b++)
    begin
      if (req.wstrb[b])
        model_mem[idx][8*b +: 8] = req.wdata[8*b +: 8];
    end
    model_init[idx] = 1'b1;
  endtask

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_rsp(input string what, input mem_rsp_t got, input mem_rsp_t want);
    if (got !== want)
    begin
      $display("Mismatch at %0t ns: %s rdata %h, expected %h", $time, what, got.rdata,
               want.rdata);
      abort_run();
    end
  endtask

  task automatic check_tx(input logic [7:0] got, input logic [7:0] want);
    if (got !== want)
    begin
      $display("Mismatch at %0t ns: uart byte %h, expected %h", $time, got, want);
      abort_run();
    end
  endtask

  task automatic check_cycles(input string what, input int got, input int want);
    if (got != want)
    begin
      $display("Mismatch at %0t ns: %s took %0d cycles, expected %0d", $time, what, got, want);
      abort_run();
    end
  endtask

  // outputs are sampled mid-cycle
  always @(negedge clk)
  begin : compare_proc
    exp_t e;
    if (!rst)
    begin
      if (lsu_rsp_valid)
      begin
        if (exp_lsu_q.size() == 0)
        begin
          $display("Error at %0t ns: lsu response with no request outstanding", $time);
          abort_run();
        end
        e = exp_lsu_q.pop_front();
        check_rsp("lsu", lsu_rsp, e.rsp);
        if (e.lat != 0)
          check_cycles("lsu access", int'(cyc - e.strobe_cyc), int'(e.lat));
        lsu_last_cyc = cyc;
        lsu_rsp_cnt++;
      end
      if (ifu_rsp_valid)
      begin
        if (exp_ifu_q.size() == 0)
        begin
          $display("Error at %0t ns: ifu response with no fetch outstanding", $time);
          abort_run();
        end
        e = exp_ifu_q.pop_front();
        check_rsp("ifu", ifu_rsp, e.rsp);
        if (e.lat != 0)
          check_cycles("ifu fetch", int'(cyc - e.strobe_cyc), int'(e.lat));
        ifu_last_cyc = cyc;
        ifu_rsp_cnt++;
      end
      if (uart_tx_valid)
      begin
        if (exp_tx_q.size() == 0)
        begin
          $display("Error at %0t ns: uart strobe with no byte expected", $time);
          abort_run();
        end
        check_tx(uart_tx_data, exp_tx_q.pop_front());
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic pulse();
    next_cycle();
    lsu_req_valid = 1'b0;
    ifu_req_valid = 1'b0;
  endtask

  task automatic wait_both(input int lsu_target, input int ifu_target);
    int waited;
    waited = 0;
    while (lsu_rsp_cnt < lsu_target || ifu_rsp_cnt < ifu_target)
    begin
      if (waited == RSP_TIMEOUT)
      begin
        $display("Error at %0t ns: no response within %0d cycles", $time, RSP_TIMEOUT);
        abort_run();
      end
      next_cycle();
      waited++;
    end
  endtask

  task automatic lsu_issue(input mem_req_t req, input int lat);
    exp_t e;
    e.rsp        = ref_rsp(req, cyc);
    e.strobe_cyc = cyc;
    e.lat        = lat;
    exp_lsu_q.push_back(e);
    if (req.we && req.addr == UART_TX_ADDR)
    begin
      if (req.wstrb != 4'd0)
        exp_tx_q.push_back(ref_tx_byte(req));
    end
    else if (req.we)
      model_write(req);
    lsu_req_valid = 1'b1;
    lsu_req       = req;
  endtask

  task automatic ifu_issue(input logic [31:0] addr, input int lat);
    exp_t e;
    ifu_req      = make_req(addr, 1'b0, 4'd0, 32'd0);
    e.rsp        = ref_rsp(ifu_req, cyc);
    e.strobe_cyc = cyc;
    e.lat        = lat;
    exp_ifu_q.push_back(e);
    ifu_req_valid = 1'b1;
  endtask

  task automatic run_lsu(input mem_req_t req, input int lat);
    int target;
    target = lsu_rsp_cnt + 1;
    lsu_issue(req, lat);
    pulse();
    wait_both(target, ifu_rsp_cnt);
  endtask

  task automatic run_ifu(input logic [31:0] addr, input int lat);
    int target;
    target = ifu_rsp_cnt + 1;
    ifu_issue(addr, lat);
    pulse();
    wait_both(lsu_rsp_cnt, target);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Error at %0t ns: watchdog expired, the run is hung", $time);
    abort_run();
  end

  initial
  begin : stimulus
    logic [31:0] addr;
    logic [3:0]  strb;
    int          lsu_target;
    int          ifu_target;

    rst           = 1'b1;
    ifu_req_valid = 1'b0;
    ifu_req       = '0;
    lsu_req_valid = 1'b0;
    lsu_req       = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // store then load, fresh or reused word
    for (int i = 0; i < N_STORE_LOAD; i++)
    begin
      if (written_q.size() == 0 || rand_bits(1) == 32'd1)
        addr = rand_bits(16) << 2;
      else
        addr = written_q[rand_bits(8) % written_q.size()];
      strb = 4'(rand_bits(4));
      // a word never written gets all four lanes first
      if (!model_init[word_index(addr)])
        strb = 4'hf;
      run_lsu(make_req(addr, 1'b1, strb, rand_bits(32)), SRAM_LATENCY + 1);
      written_q.push_back(addr);
      run_lsu(make_req(addr, 1'b0, 4'd0, 32'd0), SRAM_LATENCY + 1);
    end

    for (int i = 0; i < N_FETCH; i++)
      run_ifu(written_q[rand_bits(8) % written_q.size()], SRAM_LATENCY + 1);

    // both strobes in one cycle, lsu store or load against an ifu fetch
    for (int i = 0; i < N_CONTEND; i++)
    begin
      addr       = written_q[rand_bits(8) % written_q.size()];
      lsu_target = lsu_rsp_cnt + 1;
      ifu_target = ifu_rsp_cnt + 1;
      if (rand_bits(1) == 32'd1)
        lsu_issue(make_req(addr, 1'b1, 4'(rand_bits(4)), rand_bits(32)), 0);
      else
        lsu_issue(make_req(written_q[rand_bits(8) % written_q.size()], 1'b0, 4'd0, 32'd0), 0);
      ifu_issue(addr, 0);
      pulse();
      wait_both(lsu_target, ifu_target);
      if (lsu_last_cyc >= ifu_last_cyc)
      begin
        $display("Mismatch at %0t ns: lsu answered in cycle %0d, ifu in cycle %0d", $time,
                 lsu_last_cyc, ifu_last_cyc);
        abort_run();
      end
    end

    for (int i = 0; i < N_CLINT; i++)
    begin
      repeat (rand_bits(2)) next_cycle();
      addr = (i % 2 == 0) ? CLINT_MTIME_ADDR : CLINT_MTIME_ADDR + 32'd4;
      run_lsu(make_req(addr, 1'b0, 4'd0, 32'd0), 2);
    end

    // sram word behind the uart address must survive the uart stores
    run_lsu(make_req(UART_TX_ADDR & 32'h0000_03fc, 1'b1, 4'hf, rand_bits(32)), SRAM_LATENCY + 1);
    for (int i = 0; i < N_UART; i++)
    begin
      strb = (i == 0) ? 4'd0 : 4'(rand_bits(4));
      run_lsu(make_req(UART_TX_ADDR, 1'b1, strb, rand_bits(32)), 2);
      if (exp_tx_q.size() != 0)
      begin
        $display("Error at %0t ns: uart store produced no byte", $time);
        abort_run();
      end
    end
    run_lsu(make_req(UART_TX_ADDR & 32'h0000_03fc, 1'b0, 4'd0, 32'd0), SRAM_LATENCY + 1);
    // a load at the uart address is not decoded and reads the sram
    run_lsu(make_req(UART_TX_ADDR, 1'b0, 4'd0, 32'd0), SRAM_LATENCY + 1);

    repeat (10) next_cycle();
    if (exp_lsu_q.size() == 0 && exp_ifu_q.size() == 0 && exp_tx_q.size() == 0)
    begin
      $display("Verification passed");
      $finish;
    end
    else
    begin
      $display("Error: %0d lsu, %0d ifu and %0d uart results never arrived",
               exp_lsu_q.size(), exp_ifu_q.size(), exp_tx_q.size());
      abort_run();
    end
  end

endmodule

//--- soc_bus.f
design/soc_bus_pkg.sv
design/bus_arbiter.sv
design/sram_memory.sv
design/clint_timer.sv
design/uart_tx_port.sv
design/soc_bus_top.sv
verification/soc_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the soc_bus testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module soc_bus_tb -f soc_bus.f -o soc_bus_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/soc_bus_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi
